// ==== etx.f ====
+incdir+common
common/emesh_pkg.sv
common/etx_link_pkg.sv
hdl/emesh_unpack.sv
hdl/wait_sync.sv
etx/etx_protocol.sv
etx/etx_serializer.sv
hdl/etx_top.sv
bench/etx_assertions.sv
bench/etx_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module etx_tb -f etx.f -o etx_sim \
  && ./obj_dir/etx_sim | tee /dev/stderr | grep -q "Result: PASSED" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// ==== bench/etx_tb.sv ====
`timescale 1ns/1ps
`include "etx_params.svh"

module etx_tb;

  localparam int CLK_HALF  = 50;     // 100 ns period
  localparam int RESET_CYC = 5;
  localparam int N_OFFERS  = 400;

  logic                     clk;
  logic                     reset;
  logic                     etx_access;
  emesh_pkg::emesh_packet_t etx_packet;
  logic                     tx_enable;
  logic                     etx_rd_wait;
  logic                     etx_wr_wait;
  etx_link_pkg::lane_t      lnk_data;
  logic                     lnk_frame;
  logic                     lnk_burst;
  logic                     lnk_rd_wait;
  logic                     lnk_wr_wait;

  integer seed = 92622;
  logic   taken;                    // Offer consumed at the coming edge
  int     rd_hold;                  // Cycles left on the far read wait
  int     wr_hold;

  logic [8:0] exp_q[$];             // Burst flag above the lane byte

  // Far side waits as the synchronizer sees them, rd above wr
  logic [1:0] sync_meta;
  logic [1:0] sync_out;

  // Last forwarded packet
  logic        last_valid;
  logic        last_write;
  logic [1:0]  last_datamode;
  logic [3:0]  last_ctrlmode;
  logic [31:0] last_dstaddr;

  int full_frames  = 0;
  int burst_frames = 0;
  int dropped      = 0;

  etx_top u_dut (
    .clk         (clk),
    .reset       (reset),
    .etx_access  (etx_access),
    .etx_packet  (etx_packet),
    .tx_enable   (tx_enable),
    .etx_rd_wait (etx_rd_wait),
    .etx_wr_wait (etx_wr_wait),
    .lnk_data    (lnk_data),
    .lnk_frame   (lnk_frame),
    .lnk_burst   (lnk_burst),
    .lnk_rd_wait (lnk_rd_wait),
    .lnk_wr_wait (lnk_wr_wait)
  );

  bind etx_serializer etx_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .tx_io_wait (tx_io_wait),
    .lnk_frame  (lnk_frame),
    .lnk_burst  (lnk_burst)
  );

  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ####################
  // Helpers
  // ####################
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Write in the low bit and the spare bit on top
  function automatic emesh_pkg::emesh_packet_t make_packet(input logic w,
                                                           input logic [1:0] dm,
                                                           input logic [3:0] ctrl,
                                                           input logic [31:0] dst,
                                                           input logic [31:0] data,
                                                           input logic [31:0] src);
    return {1'b0, src, data, dst, ctrl, dm, w};
  endfunction

  task automatic push_word(input logic [31:0] word, input logic burst);
    for (int k = 3; k >= 0; k--)
    begin
      exp_q.push_back({burst, word[k*8 +: 8]});   // MSB first
    end
  endtask

  // Step one clock and then move the far side waits
  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (rd_hold > 0)
      rd_hold--;
    else if (rand_below(40) == 0)
      rd_hold = 1 + rand_below(6);
    if (wr_hold > 0)
      wr_hold--;
    else if (rand_below(40) == 0)
      wr_hold = 1 + rand_below(6);
    lnk_rd_wait = (rd_hold > 0);
    lnk_wr_wait = (wr_hold > 0);
  endtask

  // Hold the offer until the observer sees it taken
  task automatic offer_packet(input emesh_pkg::emesh_packet_t pkt, input logic en);
    etx_packet = pkt;
    tx_enable  = en;
    etx_access = 1'b1;
    taken      = 1'b0;
    do
      next_cycle();
    while (!taken);
    etx_access = 1'b0;
  endtask

  // ####################
  // Reference model
  // ####################
  task automatic model_consume(input emesh_pkg::emesh_packet_t pkt, input logic en);
    logic        w;
    logic [1:0]  dm;
    logic [3:0]  ctrl;
    logic [31:0] dst;
    logic [31:0] data;
    logic [31:0] src;
    logic        burst;
    w    = pkt[0];
    dm   = pkt[2:1];
    ctrl = pkt[6:3];
    dst  = pkt[38:7];
    data = pkt[70:39];
    src  = pkt[102:71];
    if (!en || dst[31:20] == `ETX_ID)
    begin
      dropped++;                     // Disabled or local packets send no frame
    end
    else
    begin
      burst = w && (dm == emesh_pkg::DOUBLE) && last_valid &&
              (last_write == w) && (last_datamode == dm) && (last_ctrlmode == ctrl) &&
              (dst == last_dstaddr + emesh_pkg::BURST_STRIDE);
      if (burst)
      begin
        push_word(data, 1'b1);       // Header and dstaddr left out
        push_word(src, 1'b1);
        burst_frames++;
      end
      else
      begin
        exp_q.push_back({1'b0, ctrl, dm, w, 1'b0});
        push_word(dst, 1'b0);
        push_word(data, 1'b0);
        push_word(src, 1'b0);
        full_frames++;
      end
      last_valid    = 1'b1;
      last_write    = w;
      last_datamode = dm;
      last_ctrlmode = ctrl;
      last_dstaddr  = dst;
    end
  endtask

  task automatic check_byte();
    logic [8:0] exp;
    assert (exp_q.size() != 0)
      else fail_run("lane byte sent while no frame was expected");
    exp = exp_q.pop_front();
    assert (lnk_data == exp[7:0])
      else fail_run($sformatf("mismatch lnk_data expected 0x%h actual 0x%h",
                              exp[7:0], lnk_data));
    assert (lnk_burst == exp[8])
      else fail_run($sformatf("mismatch lnk_burst expected 0x%h actual 0x%h",
                              exp[8], lnk_burst));
  endtask

  // Observer runs mid-cycle where everything has settled
  always @(negedge clk)
  begin
    if (reset)
    begin
      sync_meta = 2'b00;
      sync_out  = 2'b00;
    end
    else
    begin
      assert (!sync_out[1] || etx_rd_wait)
        else fail_run("read wait output low while the far read wait is high");
      assert (!sync_out[0] || etx_wr_wait)
        else fail_run("write wait output low while the far write wait is high");
      if (etx_access && !(etx_packet[0] ? etx_wr_wait : etx_rd_wait))
      begin
        taken = 1'b1;
        model_consume(etx_packet, tx_enable);
      end
      if (lnk_frame)
        check_byte();
      sync_out  = sync_meta;          // State after the coming edge
      sync_meta = {lnk_rd_wait, lnk_wr_wait};
    end
  end

  // Watchdog allows 20 cycles per offer
  initial
  begin
    #(N_OFFERS * 20 * 2 * CLK_HALF);
    fail_run("watchdog expired before all frames were sent");
  end

  // ####################
  // Stimulus
  // ####################
  initial
  begin
    logic [31:0] rnd;
    logic [31:0] run_dst;
    logic [3:0]  run_ctrl;
    logic [11:0] up;
    logic        w;
    logic [1:0]  dm;
    logic [3:0]  ctrl;
    logic [31:0] dst;
    int          kind;
    reset       = 1'b1;
    etx_access  = 1'b0;
    etx_packet  = '0;
    tx_enable   = 1'b0;
    lnk_rd_wait = 1'b0;
    lnk_wr_wait = 1'b0;
    taken       = 1'b0;
    rd_hold     = 0;
    wr_hold     = 0;
    last_valid  = 1'b0;             // Record empty after reset
    run_dst     = 32'h0000_1000;
    run_ctrl    = 4'h0;
    repeat (RESET_CYC) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    assert (!etx_rd_wait && !etx_wr_wait && !lnk_frame && !lnk_burst)
      else fail_run("outputs not idle after reset");
    next_cycle();

    for (int i = 0; i < N_OFFERS; i++)
    begin
      rnd  = $random(seed);
      kind = rand_below(16);
      if (kind < 9)
      begin
        w    = 1'b1;                 // Continue the double write run
        dm   = emesh_pkg::DOUBLE;
        ctrl = (kind == 8) ? run_ctrl ^ 4'h1 : run_ctrl;   // Mode break now and then
        dst  = run_dst + 32'd8;
      end
      else if (kind < 11)
      begin
        w    = rnd[30];              // Addressed to this chip
        dm   = rnd[1:0];
        ctrl = {2'b00, rnd[5:4]};
        dst  = {`ETX_ID, rnd[19:3], 3'b000};
      end
      else
      begin
        up = rnd[31:20];
        if (up == `ETX_ID)
          up = up ^ 12'h001;
        w    = (rand_below(4) != 0);
        dm   = rnd[1:0];
        ctrl = {2'b00, rnd[5:4]};
        dst  = {up, rnd[19:3], 3'b000};
      end
      run_dst  = dst;
      run_ctrl = ctrl;
      offer_packet(make_packet(w, dm, ctrl, dst, $random(seed), $random(seed)),
                   rand_below(16) != 0);
      if (rand_below(4) == 0)
        next_cycle();                // Idle gap
    end

    // Drain the lane
    while (exp_q.size() != 0 || lnk_frame)
      next_cycle();
    repeat (3) next_cycle();
    @(negedge clk);
    $display("frames: %0d full, %0d burst, %0d dropped", full_frames, burst_frames, dropped);
    assert (burst_frames > 0 && dropped > 0)
      else fail_run("stimulus produced no burst frame or no dropped packet");
    if (exp_q.size() == 0 && !lnk_frame)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
    begin
      fail_run("frames still pending at the end of the run");
    end
  end

endmodule

// ==== bench/etx_assertions.sv ====
`timescale 1ns/1ps
`include "etx_params.svh"

module etx_assertions (
  input logic clk,
  input logic reset,
  input logic tx_io_wait,
  input logic lnk_frame,
  input logic lnk_burst
);

  localparam logic [3:0] FULL_LAST  = 4'(`ETX_FULL_BYTES - 1);
  localparam logic [3:0] BURST_LAST = 4'(`ETX_BURST_BYTES - 1);

  logic [3:0] frame_len;   // Bytes of this frame already on the lane

  // Busy drops on the last byte, so that byte closes the frame
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      frame_len <= 4'd0;
    end
    else if (lnk_frame)
    begin
      frame_len <= tx_io_wait ? frame_len + 4'd1 : 4'd0;
    end
  end

  // ####################
  // Framing
  // ####################
  frame_end_len: assert property (@(posedge clk) disable iff (reset)
    (lnk_frame && !tx_io_wait) |-> (frame_len == (lnk_burst ? BURST_LAST : FULL_LAST)))
    else $error("frame closed after the wrong number of bytes");

  frame_max_len: assert property (@(posedge clk) disable iff (reset)
    lnk_frame |-> (frame_len <= (lnk_burst ? BURST_LAST : FULL_LAST)))
    else $error("frame ran past its length");

  burst_in_frame: assert property (@(posedge clk) disable iff (reset)
    lnk_burst |-> lnk_frame)
    else $error("lnk_burst high outside a frame");

  // Serializer idle out of reset
  idle_in_reset: assert property (@(posedge clk) reset |=> !tx_io_wait)
    else $error("tx_io_wait high after a reset cycle");

endmodule

// ==== hdl/etx_top.sv ====
`timescale 1ns/1ps
`include "etx_params.svh"

module etx_top #(
  parameter logic [11:0] ID = `ETX_ID
) (
  input  logic                     clk,
  input  logic                     reset,
  // System side
  input  logic                     etx_access,
  input  emesh_pkg::emesh_packet_t etx_packet,
  input  logic                     tx_enable,
  output logic                     etx_rd_wait,
  output logic                     etx_wr_wait,
  // Link side
  output etx_link_pkg::lane_t      lnk_data,
  output logic                     lnk_frame,
  output logic                     lnk_burst,
  input  logic                     lnk_rd_wait,    // Async from far side
  input  logic                     lnk_wr_wait
);

  logic                     rd_wait_sync;
  logic                     wr_wait_sync;
  emesh_pkg::emesh_packet_t tx_packet;
  logic                     tx_access;
  logic                     tx_burst;
  logic                     tx_io_wait;

  // Both far side waits share one synchronizer
  wait_sync #(
    .DW (2)
  ) u_wait_sync (
    .clk   (clk),
    .reset (reset),
    .in    ({lnk_rd_wait, lnk_wr_wait}),
    .out   ({rd_wait_sync, wr_wait_sync})
  );

  etx_protocol #(
    .ID (ID)
  ) u_protocol (
    .clk          (clk),
    .reset        (reset),
    .etx_access   (etx_access),
    .etx_packet   (etx_packet),
    .tx_enable    (tx_enable),
    .etx_rd_wait  (etx_rd_wait),
    .etx_wr_wait  (etx_wr_wait),
    .rd_wait_sync (rd_wait_sync),
    .wr_wait_sync (wr_wait_sync),
    .tx_packet    (tx_packet),
    .tx_access    (tx_access),
    .tx_burst     (tx_burst),
    .tx_io_wait   (tx_io_wait)
  );

  etx_serializer u_serializer (
    .clk        (clk),
    .reset      (reset),
    .tx_packet  (tx_packet),
    .tx_access  (tx_access),
    .tx_burst   (tx_burst),
    .tx_io_wait (tx_io_wait),
    .lnk_data   (lnk_data),
    .lnk_frame  (lnk_frame),
    .lnk_burst  (lnk_burst)
  );

endmodule

// ==== etx/etx_serializer.sv ====
`timescale 1ns/1ps
`include "etx_params.svh"

module etx_serializer (
  input  logic                     clk,
  input  logic                     reset,
  // From the protocol block
  input  emesh_pkg::emesh_packet_t tx_packet,
  input  logic                     tx_access,
  input  logic                     tx_burst,
  output logic                     tx_io_wait,
  // Link lane
  output etx_link_pkg::lane_t      lnk_data,
  output logic                     lnk_frame,
  output logic                     lnk_burst
);

  localparam int SW = `ETX_FULL_BYTES * 8;   // Shift register width

  // Count loaded with the bytes that follow the first one
  localparam logic [3:0] FULL_LAST  = 4'(`ETX_FULL_BYTES - 1);
  localparam logic [3:0] BURST_LAST = 4'(`ETX_BURST_BYTES - 1);

  etx_link_pkg::ser_state_t state;
  logic [3:0]               count;      // Bytes left after the one on the lane
  logic [SW-1:0]            shreg;      // Top byte is on the lane
  logic                     load;
  etx_link_pkg::lane_t      header;
  logic [SW-1:0]            full_image;
  logic [SW-1:0]            burst_image;

  // ####################
  // Frame images
  // ####################
  // Header byte is ctrlmode, datamode, write, zero
  assign header = {tx_packet[emesh_pkg::CTRLMODE_LSB +: 4],
                   tx_packet[emesh_pkg::DATAMODE_LSB +: 2],
                   tx_packet[emesh_pkg::WRITE_BIT],
                   1'b0};

  assign full_image = {header,
                       tx_packet[emesh_pkg::DSTADDR_LSB +: `ETX_AW],
                       tx_packet[emesh_pkg::DATA_LSB +: `ETX_DW],
                       tx_packet[emesh_pkg::SRCADDR_LSB +: `ETX_AW]};

  // Burst drops header and dstaddr, far side infers the address
  assign burst_image = {tx_packet[emesh_pkg::DATA_LSB +: `ETX_DW],
                        tx_packet[emesh_pkg::SRCADDR_LSB +: `ETX_AW],
                        {(SW - `ETX_DW - `ETX_AW){1'b0}}};

  // ####################
  // Handshake
  // ####################
  // Busy until the last byte, so the next load lands right behind it
  assign tx_io_wait = (state != etx_link_pkg::SER_IDLE) && (count != 4'd0);
  assign load       = tx_access & ~tx_io_wait;   // Idle or on last byte

  assign lnk_frame = (state != etx_link_pkg::SER_IDLE);
  assign lnk_data  = shreg[SW-1 -: 8];

  // ####################
  // FSM
  // ####################
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= etx_link_pkg::SER_IDLE;
      count     <= 4'd0;
      lnk_burst <= 1'b0;
    end
    else if (load)
    begin
      state     <= tx_burst ? etx_link_pkg::SER_BODY : etx_link_pkg::SER_HEADER;
      count     <= tx_burst ? BURST_LAST : FULL_LAST;
      lnk_burst <= tx_burst;
    end
    else
    begin
      case (state)
        etx_link_pkg::SER_HEADER:
        begin
          state <= etx_link_pkg::SER_BODY;   // Header is always one byte
          count <= count - 4'd1;
        end
        etx_link_pkg::SER_BODY:
        begin
          if (count == 4'd0)
          begin
            state     <= etx_link_pkg::SER_IDLE;   // Nothing waiting
            lnk_burst <= 1'b0;
          end
          else
          begin
            count <= count - 4'd1;
          end
        end
        default:
        begin
          state <= etx_link_pkg::SER_IDLE;
        end
      endcase
    end
  end

  // Payload shift, MSB first
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      shreg <= tx_burst ? burst_image : full_image;
    end
    else if (state != etx_link_pkg::SER_IDLE)
    begin
      shreg <= {shreg[SW-9:0], 8'h00};
    end
  end

endmodule

// ==== etx/etx_protocol.sv ====
`timescale 1ns/1ps
`include "etx_params.svh"

module etx_protocol #(
  parameter logic [11:0] ID = `ETX_ID
) (
  input  logic                     clk,
  input  logic                     reset,
  // System side
  input  logic                     etx_access,
  input  emesh_pkg::emesh_packet_t etx_packet,
  input  logic                     tx_enable,
  output logic                     etx_rd_wait,
  output logic                     etx_wr_wait,
  // Far side waits after the synchronizer
  input  logic                     rd_wait_sync,
  input  logic                     wr_wait_sync,
  // Serializer side
  output emesh_pkg::emesh_packet_t tx_packet,
  output logic                     tx_access,
  output logic                     tx_burst,
  input  logic                     tx_io_wait
);

  // Incoming packet fields
  logic                 in_write;
  emesh_pkg::datamode_t in_datamode;
  logic [3:0]           in_ctrlmode;
  logic [`ETX_AW-1:0]   in_dstaddr;

  // Last forwarded packet fields
  logic                 last_write;
  emesh_pkg::datamode_t last_datamode;
  logic [3:0]           last_ctrlmode;
  logic [`ETX_AW-1:0]   last_dstaddr;

  logic consumed;      // Taken from the sender this cycle
  logic local_hit;     // Addressed to this chip
  logic forward;
  logic type_match;
  logic burst_match;

  // ####################
  // Field decode
  // ####################
  emesh_unpack u_unpack_in (
    .packet   (etx_packet),
    .write    (in_write),
    .datamode (in_datamode),
    .ctrlmode (in_ctrlmode),
    .dstaddr  (in_dstaddr),
    .data     (),
    .srcaddr  ()
  );

  // Held packet doubles as the burst record
  emesh_unpack u_unpack_last (
    .packet   (tx_packet),
    .write    (last_write),
    .datamode (last_datamode),
    .ctrlmode (last_ctrlmode),
    .dstaddr  (last_dstaddr),
    .data     (),
    .srcaddr  ()
  );

  // ####################
  // Wait generation
  // ####################
  // Serializer busy stalls both directions
  assign etx_rd_wait = rd_wait_sync | tx_io_wait;
  assign etx_wr_wait = wr_wait_sync | tx_io_wait;

  // ####################
  // Acceptance and filter
  // ####################
  // Direction picks which wait applies
  assign consumed  = etx_access & (in_write ? ~etx_wr_wait : ~etx_rd_wait);
  assign local_hit = (in_dstaddr[`ETX_AW-1 -: 12] == ID);
  assign forward   = consumed & tx_enable & ~local_hit;   // Others silently dropped

  // ####################
  // Burst detection
  // ####################
  assign type_match = ({in_ctrlmode, in_datamode, in_write} ==
                       {last_ctrlmode, last_datamode, last_write});

  assign burst_match = in_write &
                       (in_datamode == emesh_pkg::DOUBLE) &
                       type_match &
                       (in_dstaddr == last_dstaddr + emesh_pkg::BURST_STRIDE);

  // ####################
  // Output register
  // ####################
  // Holds while the serializer is busy
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tx_access <= 1'b0;
      tx_burst  <= 1'b0;
      tx_packet <= '0;          // Record cleared, read type never matches a burst
    end
    else if (~tx_io_wait)
    begin
      tx_access <= forward;
      tx_burst  <= forward & burst_match;
      if (forward)
      begin
        tx_packet <= etx_packet;  // Only forwarded packets update the record
      end
    end
  end

endmodule

// ==== hdl/wait_sync.sv ====
`timescale 1ns/1ps

module wait_sync #(
  parameter int DW = 1
) (
  input  logic          clk,
  input  logic          reset,
  input  logic [DW-1:0] in,      // Async levels from the far side
  output logic [DW-1:0] out
);

  logic [DW-1:0] meta;   // First stage, may go metastable

  // Two flops in series
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      meta <= '0;
      out  <= '0;
    end
    else
    begin
      meta <= in;
      out  <= meta;
    end
  end

endmodule

// ==== hdl/emesh_unpack.sv ====
`timescale 1ns/1ps
`include "etx_params.svh"

module emesh_unpack (
  input  emesh_pkg::emesh_packet_t packet,
  output logic                     write,
  output emesh_pkg::datamode_t     datamode,
  output logic [3:0]               ctrlmode,
  output logic [`ETX_AW-1:0]       dstaddr,
  output logic [`ETX_DW-1:0]       data,
  output logic [`ETX_AW-1:0]       srcaddr
);

  // Control fields in the low bits
  assign write    = packet[emesh_pkg::WRITE_BIT];
  assign datamode = emesh_pkg::datamode_t'(packet[emesh_pkg::DATAMODE_LSB +: 2]);
  assign ctrlmode = packet[emesh_pkg::CTRLMODE_LSB +: 4];

  // Address and payload words
  assign dstaddr  = packet[emesh_pkg::DSTADDR_LSB +: `ETX_AW];
  assign data     = packet[emesh_pkg::DATA_LSB +: `ETX_DW];
  assign srcaddr  = packet[emesh_pkg::SRCADDR_LSB +: `ETX_AW];   // Return address

endmodule

// ==== common/etx_link_pkg.sv ====
package etx_link_pkg;

  // One byte of the link lane
  typedef logic [7:0] lane_t;

  // Serializer FSM
  typedef enum logic [1:0] {
    SER_IDLE   = 2'd0,  // Lane quiet
    SER_HEADER = 2'd1,  // Header byte on the lane
    SER_BODY   = 2'd2   // Address and data bytes on the lane
  } ser_state_t;

endpackage

// ==== common/emesh_pkg.sv ====
package emesh_pkg;

`include "etx_params.svh"

  // Flat packet as seen on the system side
  typedef logic [`ETX_PW-1:0] emesh_packet_t;

  // Transfer size
  typedef enum logic [1:0] {
    BYTE   = 2'b00,
    HALF   = 2'b01,
    WORD   = 2'b10,
    DOUBLE = 2'b11   // Only size that may burst
  } datamode_t;

  // ####################
  // Field positions
  // ####################
  localparam int WRITE_BIT    = 0;
  localparam int DATAMODE_LSB = 1;    // 2 bits
  localparam int CTRLMODE_LSB = 3;    // 4 bits
  localparam int DSTADDR_LSB  = 7;
  localparam int DATA_LSB     = DSTADDR_LSB + `ETX_AW;
  localparam int SRCADDR_LSB  = DATA_LSB + `ETX_DW;
  // Top bit above srcaddr is spare

  // Address step between consecutive burst beats
  localparam logic [`ETX_AW-1:0] BURST_STRIDE = 8;

endpackage

// ==== common/etx_params.svh ====
`ifndef ETX_PARAMS_SVH
`define ETX_PARAMS_SVH

// ####################
// Mesh packet geometry
// ####################
`define ETX_PW 104            // Flat packet width
`define ETX_AW 32             // Address width
`define ETX_DW 32             // Data width

// ####################
// Chip identity
// ####################
`define ETX_ID 12'h810        // Upper address bits of the local chip

// ####################
// Link framing
// ####################
`define ETX_FULL_BYTES 13     // Header plus dstaddr, data, srcaddr
`define ETX_BURST_BYTES 8     // Data plus srcaddr only

`endif
